// ==== src/rv32_consts.svh ====
// rv32 core constants: opcodes, store funct3, alu, branch, load, store, write-back, operand-a codes
`ifndef RV32_CONSTS_SVH
`define RV32_CONSTS_SVH

// major opcodes of the rv32i subset handled by the core
`define RV32_OP_LUI    7'b0110111
`define RV32_OP_AUIPC  7'b0010111
`define RV32_OP_JAL    7'b1101111
`define RV32_OP_JALR   7'b1100111
`define RV32_OP_BRANCH 7'b1100011
`define RV32_OP_LOAD   7'b0000011
`define RV32_OP_STORE  7'b0100011
`define RV32_OP_OP_IMM 7'b0010011
`define RV32_OP_OP     7'b0110011

// funct3 values of the three store widths
`define RV32_F3_SB 3'b000
`define RV32_F3_SH 3'b001
`define RV32_F3_SW 3'b010

// alu codes follow {funct7[5], funct3} so register and immediate ops decode directly
// pass_b has no instruction encoding of its own and is used for lui
`define RV32_ALU_ADD    4'b0000
`define RV32_ALU_SLL    4'b0001
`define RV32_ALU_SLT    4'b0010
`define RV32_ALU_SLTU   4'b0011
`define RV32_ALU_XOR    4'b0100
`define RV32_ALU_SRL    4'b0101
`define RV32_ALU_OR     4'b0110
`define RV32_ALU_AND    4'b0111
`define RV32_ALU_SUB    4'b1000
`define RV32_ALU_SRA    4'b1101
`define RV32_ALU_PASS_B 4'b1111

// branch codes reuse the branch funct3 values, none takes one of the two unused ones
`define RV32_BR_EQ   3'b000
`define RV32_BR_NE   3'b001
`define RV32_BR_NONE 3'b010
`define RV32_BR_LT   3'b100
`define RV32_BR_GE   3'b101
`define RV32_BR_LTU  3'b110
`define RV32_BR_GEU  3'b111

// load codes are the load funct3 values
`define RV32_LD_LB  3'b000
`define RV32_LD_LH  3'b001
`define RV32_LD_LW  3'b010
`define RV32_LD_LBU 3'b100
`define RV32_LD_LHU 3'b101

// store kinds
`define RV32_ST_NONE 2'b00
`define RV32_ST_SB   2'b01
`define RV32_ST_SH   2'b10
`define RV32_ST_SW   2'b11

// write-back sources
`define RV32_WB_ALU  2'b00
`define RV32_WB_LOAD 2'b01
`define RV32_WB_PC4  2'b10

// alu operand a sources
`define RV32_OPA_RS1  2'b00
`define RV32_OPA_PC   2'b01
`define RV32_OPA_ZERO 2'b10

// first instruction fetched after reset
`define RV32_RESET_PC 32'h0000_0000

`endif

// ==== src/rv32_pkg.sv ====
// rv32 vector typedefs shared by the core blocks and the testbench
package rv32_pkg;

  // data word, byte address or instruction
  typedef logic [31:0] word_t;

  // index into the 32-entry register file
  typedef logic [4:0] reg_addr_t;

  // alu operation, values in rv32_consts.svh
  typedef logic [3:0] alu_op_t;

  // branch condition selector
  typedef logic [2:0] br_op_t;

  // load width and extension kind
  typedef logic [2:0] ld_op_t;

  // store width, zero means no store
  typedef logic [1:0] st_op_t;

  // source of the value written to rd
  typedef logic [1:0] wb_sel_t;

  // source of alu operand a
  typedef logic [1:0] opa_sel_t;

  // one write enable per byte lane of the data memory
  // bit 0 is the lane at address bits 1:0 equal to zero
  typedef logic [3:0] byte_en_t;

endpackage

// ==== src/rv32_regfile.sv ====
// rv32_regfile: 31 writable registers, two combinational read ports, x0 reads zero
`timescale 1ns/10ps

module rv32_regfile (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                reg_wr,
  input  rv32_pkg::reg_addr_t rs1_addr,
  input  rv32_pkg::reg_addr_t rs2_addr,
  input  rv32_pkg::reg_addr_t rd_addr,
  input  rv32_pkg::word_t     rd_data,
  output rv32_pkg::word_t     rs1_data,
  output rv32_pkg::word_t     rs2_data
);

  // x0 has no storage, so the array starts at index 1
  rv32_pkg::word_t regs [1:31];

  // the whole array clears while reset is held
  // writes to x0 are dropped here rather than in decode
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_wr && (rd_addr != '0)) begin
      regs[rd_addr] <= rd_data;
    end
  end

  // reads are asynchronous so the single-cycle path sees operands at once
  // a write lands on the edge, so a same-cycle read still returns the old value
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== src/rv32_fetch.sv ====
// rv32_fetch: program counter register and next-pc selection
`timescale 1ns/10ps

`include "rv32_consts.svh"

module rv32_fetch (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            take_branch,
  input  rv32_pkg::word_t target,
  output rv32_pkg::word_t pc
);

  // address of the next instruction in program order
  rv32_pkg::word_t seq_pc;

  // next value of the program counter
  rv32_pkg::word_t next_pc;

  assign seq_pc = pc + 32'd4;

  // execute has already folded the branch condition and jumps into take_branch
  // target arrives with bit 0 cleared for jalr
  assign next_pc = take_branch ? target : seq_pc;

  // one instruction retires per edge, so the pc moves every cycle
  // reset parks it on the reset vector
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= `RV32_RESET_PC;
    end else begin
      pc <= next_pc;
    end
  end

endmodule

// ==== src/rv32_decode.sv ====
// rv32_decode: field extraction, immediate generation and control decoding
`timescale 1ns/10ps

`include "rv32_consts.svh"

module rv32_decode (
  input  logic                rst_n,
  input  rv32_pkg::word_t     instr,
  output rv32_pkg::reg_addr_t rs1_addr,
  output rv32_pkg::reg_addr_t rs2_addr,
  output rv32_pkg::reg_addr_t rd_addr,
  output rv32_pkg::word_t     imm,
  output logic                reg_wr,
  output rv32_pkg::alu_op_t   alu_op,
  output rv32_pkg::opa_sel_t  opa_sel,
  output logic                opb_imm,
  output rv32_pkg::br_op_t    br_op,
  output logic                jump,
  output logic                jalr,
  output rv32_pkg::ld_op_t    ld_op,
  output rv32_pkg::st_op_t    st_op,
  output rv32_pkg::wb_sel_t   wb_sel
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic            funct7_5;
  logic            shift_right;
  rv32_pkg::word_t imm_i;
  rv32_pkg::word_t imm_s;
  rv32_pkg::word_t imm_b;
  rv32_pkg::word_t imm_u;
  rv32_pkg::word_t imm_j;

  // register fields sit at fixed positions in every format
  // formats without rs2 or rd just leave the field unused
  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];
  assign rd_addr  = instr[11:7];
  assign opcode   = instr[6:0];
  assign funct3   = instr[14:12];
  assign funct7_5 = instr[30];

  // srli and srai share funct3 101; bit 30 picks the arithmetic form
  assign shift_right = (funct3 == 3'b101);

  // all immediates are sign extended from instruction bit 31
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    // defaults describe a no-op, which is also what unknown opcodes get
    imm     = '0;
    reg_wr  = 1'b0;
    alu_op  = `RV32_ALU_ADD;
    opa_sel = `RV32_OPA_RS1;
    opb_imm = 1'b0;
    br_op   = `RV32_BR_NONE;
    jump    = 1'b0;
    jalr    = 1'b0;
    ld_op   = `RV32_LD_LW;
    st_op   = `RV32_ST_NONE;
    wb_sel  = `RV32_WB_ALU;
    case (opcode)
      `RV32_OP_LUI: begin
        // operand a is zero, pass_b keeps the alu out of the carry chain
        imm     = imm_u;
        reg_wr  = 1'b1;
        opa_sel = `RV32_OPA_ZERO;
        opb_imm = 1'b1;
        alu_op  = `RV32_ALU_PASS_B;
      end
      `RV32_OP_AUIPC: begin
        imm     = imm_u;
        reg_wr  = 1'b1;
        opa_sel = `RV32_OPA_PC;
        opb_imm = 1'b1;
      end
      `RV32_OP_JAL: begin
        // link value comes from pc plus four in mem_wb
        imm    = imm_j;
        reg_wr = 1'b1;
        jump   = 1'b1;
        wb_sel = `RV32_WB_PC4;
      end
      `RV32_OP_JALR: begin
        imm    = imm_i;
        reg_wr = 1'b1;
        jump   = 1'b1;
        jalr   = 1'b1;
        wb_sel = `RV32_WB_PC4;
      end
      `RV32_OP_BRANCH: begin
        imm = imm_b;
        // branch codes equal funct3, the two reserved values fall through to none
        case (funct3)
          `RV32_BR_EQ, `RV32_BR_NE, `RV32_BR_LT, `RV32_BR_GE,
          `RV32_BR_LTU, `RV32_BR_GEU: br_op = funct3;
          default: br_op = `RV32_BR_NONE;
        endcase
      end
      `RV32_OP_LOAD: begin
        // address is rs1 plus offset through the alu adder
        imm     = imm_i;
        opb_imm = 1'b1;
        wb_sel  = `RV32_WB_LOAD;
        case (funct3)
          `RV32_LD_LB, `RV32_LD_LH, `RV32_LD_LW, `RV32_LD_LBU, `RV32_LD_LHU: begin
            ld_op  = funct3;
            reg_wr = 1'b1;
          end
          default: reg_wr = 1'b0;
        endcase
      end
      `RV32_OP_STORE: begin
        imm     = imm_s;
        opb_imm = 1'b1;
        case (funct3)
          `RV32_F3_SB: st_op = `RV32_ST_SB;
          `RV32_F3_SH: st_op = `RV32_ST_SH;
          `RV32_F3_SW: st_op = `RV32_ST_SW;
          default:     st_op = `RV32_ST_NONE;
        endcase
      end
      `RV32_OP_OP_IMM: begin
        // bit 30 belongs to the immediate except on right shifts
        imm     = imm_i;
        reg_wr  = 1'b1;
        opb_imm = 1'b1;
        alu_op  = {shift_right & funct7_5, funct3};
      end
      `RV32_OP_OP: begin
        // funct7 bit 5 turns add into sub and srl into sra
        reg_wr = 1'b1;
        alu_op = {funct7_5, funct3};
      end
      default: begin
      end
    endcase
    // nothing may reach the register file or data memory while reset is held
    if (!rst_n) begin
      reg_wr = 1'b0;
      st_op  = `RV32_ST_NONE;
    end
  end

endmodule

// ==== src/rv32_execute.sv ====
// rv32_execute: operand selection, alu, branch compare and branch/jump target
`timescale 1ns/10ps

`include "rv32_consts.svh"

module rv32_execute (
  input  rv32_pkg::word_t    pc,
  input  rv32_pkg::word_t    rs1_data,
  input  rv32_pkg::word_t    rs2_data,
  input  rv32_pkg::word_t    imm,
  input  rv32_pkg::alu_op_t  alu_op,
  input  rv32_pkg::opa_sel_t opa_sel,
  input  logic               opb_imm,
  input  rv32_pkg::br_op_t   br_op,
  input  logic               jump,
  input  logic               jalr,
  output rv32_pkg::word_t    alu_result,
  output logic               take_branch,
  output rv32_pkg::word_t    target
);

  rv32_pkg::word_t op_a;
  rv32_pkg::word_t op_b;
  logic [4:0]      shamt;
  logic            eq;
  logic            lt_s;
  logic            lt_u;
  logic            cond_met;
  rv32_pkg::word_t target_sum;

  // operand a is pc for auipc and zero for lui
  always_comb begin
    case (opa_sel)
      `RV32_OPA_RS1: op_a = rs1_data;
      `RV32_OPA_PC:  op_a = pc;
      default:       op_a = '0;
    endcase
  end

  assign op_b = opb_imm ? imm : rs2_data;

  // only the low five bits count as shift amount
  assign shamt = op_b[4:0];

  always_comb begin
    case (alu_op)
      `RV32_ALU_ADD:    alu_result = op_a + op_b;
      `RV32_ALU_SUB:    alu_result = op_a - op_b;
      `RV32_ALU_SLL:    alu_result = op_a << shamt;
      `RV32_ALU_SLT:    alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      `RV32_ALU_SLTU:   alu_result = {31'b0, op_a < op_b};
      `RV32_ALU_XOR:    alu_result = op_a ^ op_b;
      `RV32_ALU_SRL:    alu_result = op_a >> shamt;
      `RV32_ALU_SRA:    alu_result = $signed(op_a) >>> shamt;
      `RV32_ALU_OR:     alu_result = op_a | op_b;
      `RV32_ALU_AND:    alu_result = op_a & op_b;
      `RV32_ALU_PASS_B: alu_result = op_b;
      default:          alu_result = '0;
    endcase
  end

  // branches always compare the two registers, never the immediate
  assign eq   = (rs1_data == rs2_data);
  assign lt_s = ($signed(rs1_data) < $signed(rs2_data));
  assign lt_u = (rs1_data < rs2_data);

  always_comb begin
    case (br_op)
      `RV32_BR_EQ:  cond_met = eq;
      `RV32_BR_NE:  cond_met = !eq;
      `RV32_BR_LT:  cond_met = lt_s;
      `RV32_BR_GE:  cond_met = !lt_s;
      `RV32_BR_LTU: cond_met = lt_u;
      `RV32_BR_GEU: cond_met = !lt_u;
      default:      cond_met = 1'b0;
    endcase
  end

  // jumps are unconditional, so fetch only needs the one select line
  assign take_branch = jump | cond_met;

  // jalr is relative to rs1 and drops bit 0, every other target is pc relative
  assign target_sum = (jalr ? rs1_data : pc) + imm;
  assign target     = {target_sum[31:1], target_sum[0] & ~jalr};

endmodule

// ==== src/rv32_mem_wb.sv ====
// rv32_mem_wb: store lane placement and enables, load extraction, write-back select
`timescale 1ns/10ps

`include "rv32_consts.svh"

module rv32_mem_wb (
  input  rv32_pkg::word_t    pc,
  input  rv32_pkg::word_t    alu_result,
  input  rv32_pkg::word_t    rs2_data,
  input  rv32_pkg::ld_op_t   ld_op,
  input  rv32_pkg::st_op_t   st_op,
  input  rv32_pkg::wb_sel_t  wb_sel,
  input  rv32_pkg::word_t    data_in,
  output rv32_pkg::word_t    data_addr,
  output rv32_pkg::byte_en_t datamem_wr,
  output rv32_pkg::word_t    data_out,
  output rv32_pkg::word_t    rd_data
);

  logic [1:0]      lane;
  rv32_pkg::word_t ld_shifted;
  rv32_pkg::word_t ld_data;

  // loads and stores both use the alu sum as byte address
  assign data_addr = alu_result;

  // misalignment is not trapped, the low bits only pick the lane
  assign lane = alu_result[1:0];

  // bytes and halves move up into their lane with every other lane zero
  always_comb begin
    case (st_op)
      `RV32_ST_SB: begin
        data_out   = {24'b0, rs2_data[7:0]} << {lane, 3'b000};
        datamem_wr = 4'b0001 << lane;
      end
      `RV32_ST_SH: begin
        data_out   = {16'b0, rs2_data[15:0]} << {lane[1], 4'b0000};
        datamem_wr = lane[1] ? 4'b1100 : 4'b0011;
      end
      `RV32_ST_SW: begin
        data_out   = rs2_data;
        datamem_wr = 4'b1111;
      end
      default: begin
        data_out   = '0;
        datamem_wr = '0;
      end
    endcase
  end

  // bring the addressed lane down to bit 0 before extending
  assign ld_shifted = data_in >> {lane, 3'b000};

  always_comb begin
    case (ld_op)
      `RV32_LD_LB:  ld_data = {{24{ld_shifted[7]}}, ld_shifted[7:0]};
      `RV32_LD_LH:  ld_data = {{16{ld_shifted[15]}}, ld_shifted[15:0]};
      `RV32_LD_LBU: ld_data = {24'b0, ld_shifted[7:0]};
      `RV32_LD_LHU: ld_data = {16'b0, ld_shifted[15:0]};
      default:      ld_data = data_in;
    endcase
  end

  // pc plus four is the link value of jal and jalr
  always_comb begin
    case (wb_sel)
      `RV32_WB_LOAD: rd_data = ld_data;
      `RV32_WB_PC4:  rd_data = pc + 32'd4;
      default:       rd_data = alu_result;
    endcase
  end

endmodule

// ==== src/rv32_core.sv ====
// rv32_core: single-cycle rv32i core joining fetch, regfile, decode, execute and mem_wb
`timescale 1ns/10ps

module rv32_core (
  input  logic               clk,
  input  logic               rst_n,
  output rv32_pkg::word_t    instr_addr,
  input  rv32_pkg::word_t    instr_in,
  output rv32_pkg::word_t    data_addr,
  output rv32_pkg::byte_en_t datamem_wr,
  input  rv32_pkg::word_t    data_in,
  output rv32_pkg::word_t    data_out
);

  // register file ports
  rv32_pkg::reg_addr_t rs1_addr;
  rv32_pkg::reg_addr_t rs2_addr;
  rv32_pkg::reg_addr_t rd_addr;
  rv32_pkg::word_t     rs1_data;
  rv32_pkg::word_t     rs2_data;
  rv32_pkg::word_t     rd_data;

  // decoded control
  rv32_pkg::word_t     imm;
  logic                reg_wr;
  rv32_pkg::alu_op_t   alu_op;
  rv32_pkg::opa_sel_t  opa_sel;
  logic                opb_imm;
  rv32_pkg::br_op_t    br_op;
  logic                jump;
  logic                jalr;
  rv32_pkg::ld_op_t    ld_op;
  rv32_pkg::st_op_t    st_op;
  rv32_pkg::wb_sel_t   wb_sel;

  // execute results
  rv32_pkg::word_t     alu_result;
  logic                take_branch;
  rv32_pkg::word_t     target;

  // the pc doubles as the instruction memory address
  rv32_fetch u_fetch (
    .clk         (clk),
    .rst_n       (rst_n),
    .take_branch (take_branch),
    .target      (target),
    .pc          (instr_addr)
  );

  rv32_decode u_decode (
    .rst_n    (rst_n),
    .instr    (instr_in),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd_addr  (rd_addr),
    .imm      (imm),
    .reg_wr   (reg_wr),
    .alu_op   (alu_op),
    .opa_sel  (opa_sel),
    .opb_imm  (opb_imm),
    .br_op    (br_op),
    .jump     (jump),
    .jalr     (jalr),
    .ld_op    (ld_op),
    .st_op    (st_op),
    .wb_sel   (wb_sel)
  );

  rv32_regfile u_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .reg_wr   (reg_wr),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv32_execute u_execute (
    .pc          (instr_addr),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .imm         (imm),
    .alu_op      (alu_op),
    .opa_sel     (opa_sel),
    .opb_imm     (opb_imm),
    .br_op       (br_op),
    .jump        (jump),
    .jalr        (jalr),
    .alu_result  (alu_result),
    .take_branch (take_branch),
    .target      (target)
  );

  // the result stage closes the loop back into the register file
  rv32_mem_wb u_mem_wb (
    .pc         (instr_addr),
    .alu_result (alu_result),
    .rs2_data   (rs2_data),
    .ld_op      (ld_op),
    .st_op      (st_op),
    .wb_sel     (wb_sel),
    .data_in    (data_in),
    .data_addr  (data_addr),
    .datamem_wr (datamem_wr),
    .data_out   (data_out),
    .rd_data    (rd_data)
  );

endmodule

// ==== verif/rv32_tb.sv ====
// clock, reset, memories, random program generator, reference model and checker for the rv32 core
`timescale 1ns/10ps

`include "rv32_consts.svh"

module rv32_tb;

  // a forward-only program needs far fewer cycles than this
  localparam int TIMEOUT_CYCLES = 2000;
  // word index of the closing self-loop
  localparam int LAST_IDX = 250;
  // x1 points into the middle of data memory so offsets reach both ends
  localparam int DATA_BASE = 512;

  logic               clk;
  logic               rst_n;
  rv32_pkg::word_t    instr_addr;
  rv32_pkg::word_t    instr_in;
  rv32_pkg::word_t    data_addr;
  rv32_pkg::byte_en_t datamem_wr;
  rv32_pkg::word_t    data_in;
  rv32_pkg::word_t    data_out;

  // memories seen by the DUT, and the model's own copies of its state
  rv32_pkg::word_t imem [256];
  rv32_pkg::word_t dmem [256];
  rv32_pkg::word_t model_mem [256];
  rv32_pkg::word_t model_regs [32];
  rv32_pkg::word_t model_pc;
  logic            is_target [256];

  logic running;
  logic done;
  int   value_errors;
  int   mem_errors;
  int   timeouts;

  rv32_core UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .instr_addr (instr_addr),
    .instr_in   (instr_in),
    .data_addr  (data_addr),
    .datamem_wr (datamem_wr),
    .data_in    (data_in),
    .data_out   (data_out)
  );

  always #50 clk = ~clk;

  // both memories are word addressed and answer within the same cycle
  assign instr_in = imem[instr_addr[9:2]];
  assign data_in  = dmem[data_addr[9:2]];

  // instruction encoders for each rv32i format
  function automatic rv32_pkg::word_t r_type(input logic [6:0] f7, input int rs2, input int rs1,
                                             input logic [2:0] f3, input int rd);
    r_type = {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `RV32_OP_OP};
  endfunction

  function automatic rv32_pkg::word_t i_type(input int imm, input int rs1, input logic [2:0] f3,
                                             input int rd, input logic [6:0] op);
    i_type = {imm[11:0], rs1[4:0], f3, rd[4:0], op};
  endfunction

  function automatic rv32_pkg::word_t s_type(input int imm, input int rs2, input int rs1,
                                             input logic [2:0] f3);
    s_type = {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], `RV32_OP_STORE};
  endfunction

  function automatic rv32_pkg::word_t b_type(input int imm, input int rs2, input int rs1,
                                             input logic [2:0] f3);
    b_type = {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], `RV32_OP_BRANCH};
  endfunction

  function automatic rv32_pkg::word_t u_type(input int imm, input int rd, input logic [6:0] op);
    u_type = {imm[19:0], rd[4:0], op};
  endfunction

  function automatic rv32_pkg::word_t j_type(input int imm, input int rd);
    j_type = {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], `RV32_OP_JAL};
  endfunction

  // random x1-relative offset aligned to 1, 2 or 4 bytes for size 0, 1 or 2
  function automatic int data_offset(input logic [1:0] size);
    int addr;
    addr = $urandom % 1024;
    if (size == 2'd1) begin
      addr = addr & ~1;
    end else if (size == 2'd2) begin
      addr = addr & ~3;
    end
    data_offset = addr - DATA_BASE;
  endfunction

  // replace the enabled byte lanes of a word
  function automatic rv32_pkg::word_t merge_bytes(input rv32_pkg::word_t old_word,
                                                  input rv32_pkg::word_t new_word,
                                                  input rv32_pkg::byte_en_t en);
    rv32_pkg::word_t merged;
    merged = old_word;
    for (int k = 0; k < 4; k++) begin
      if (en[k]) begin
        merged[8*k +: 8] = new_word[8*k +: 8];
      end
    end
    merge_bytes = merged;
  endfunction

  function automatic rv32_pkg::word_t lane_mask(input rv32_pkg::byte_en_t en);
    lane_mask = {{8{en[3]}}, {8{en[2]}}, {8{en[1]}}, {8{en[0]}}};
  endfunction

  // integer operations selected by funct3 where alt picks sub and sra
  function automatic rv32_pkg::word_t alu_model(input logic [2:0] f3, input logic alt,
                                                input rv32_pkg::word_t x,
                                                input rv32_pkg::word_t y);
    case (f3)
      3'b000: alu_model = alt ? x - y : x + y;
      3'b001: alu_model = x << y[4:0];
      3'b010: alu_model = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      3'b011: alu_model = (x < y) ? 32'd1 : 32'd0;
      3'b100: alu_model = x ^ y;
      3'b101: begin
        // alt selects the arithmetic right shift
        if (alt) begin
          alu_model = $signed(x) >>> y[4:0];
        end else begin
          alu_model = x >> y[4:0];
        end
      end
      3'b110: alu_model = x | y;
      default: alu_model = x & y;
    endcase
  endfunction

  // one rv32i instruction applied to the model state
  function automatic void reference_step(input rv32_pkg::word_t instr,
                                         input rv32_pkg::word_t pc,
                                         input rv32_pkg::word_t regs [32],
                                         input rv32_pkg::word_t mem [256],
                                         output rv32_pkg::word_t next_pc,
                                         output rv32_pkg::reg_addr_t rd,
                                         output rv32_pkg::word_t rd_val,
                                         output rv32_pkg::word_t st_addr,
                                         output rv32_pkg::byte_en_t st_en,
                                         output rv32_pkg::word_t st_data);
    logic [6:0]      op;
    logic [2:0]      f3;
    logic            take;
    rv32_pkg::word_t a;
    rv32_pkg::word_t b;
    rv32_pkg::word_t imm_i;
    rv32_pkg::word_t imm_s;
    rv32_pkg::word_t imm_b;
    rv32_pkg::word_t imm_u;
    rv32_pkg::word_t imm_j;
    rv32_pkg::word_t addr;
    rv32_pkg::word_t shifted;
    op      = instr[6:0];
    f3      = instr[14:12];
    a       = regs[instr[19:15]];
    b       = regs[instr[24:20]];
    imm_i   = {{20{instr[31]}}, instr[31:20]};
    imm_s   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    imm_b   = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    imm_u   = {instr[31:12], 12'b0};
    imm_j   = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    next_pc = pc + 32'd4;
    rd      = '0;
    rd_val  = '0;
    st_addr = '0;
    st_en   = '0;
    st_data = '0;
    take    = 1'b0;
    case (op)
      `RV32_OP_LUI: begin
        rd     = instr[11:7];
        rd_val = imm_u;
      end
      `RV32_OP_AUIPC: begin
        rd     = instr[11:7];
        rd_val = pc + imm_u;
      end
      `RV32_OP_JAL: begin
        rd      = instr[11:7];
        rd_val  = pc + 32'd4;
        next_pc = pc + imm_j;
      end
      `RV32_OP_JALR: begin
        rd      = instr[11:7];
        rd_val  = pc + 32'd4;
        next_pc = (a + imm_i) & ~32'd1;
      end
      `RV32_OP_BRANCH: begin
        case (f3)
          3'b000: take = (a == b);
          3'b001: take = (a != b);
          3'b100: take = ($signed(a) < $signed(b));
          3'b101: take = ($signed(a) >= $signed(b));
          3'b110: take = (a < b);
          3'b111: take = (a >= b);
          default: take = 1'b0;
        endcase
        if (take) begin
          next_pc = pc + imm_b;
        end
      end
      `RV32_OP_LOAD: begin
        addr    = a + imm_i;
        shifted = mem[addr[9:2]] >> (8 * addr[1:0]);
        rd      = instr[11:7];
        case (f3)
          3'b000: rd_val = {{24{shifted[7]}}, shifted[7:0]};
          3'b001: rd_val = {{16{shifted[15]}}, shifted[15:0]};
          3'b100: rd_val = {24'b0, shifted[7:0]};
          3'b101: rd_val = {16'b0, shifted[15:0]};
          default: rd_val = mem[addr[9:2]];
        endcase
      end
      `RV32_OP_STORE: begin
        // only the enabled lanes of st_data carry meaning
        addr    = a + imm_s;
        st_addr = addr;
        st_data = b << (8 * addr[1:0]);
        case (f3)
          3'b000: st_en = 4'b0001 << addr[1:0];
          3'b001: st_en = 4'b0011 << addr[1:0];
          default: st_en = 4'b1111;
        endcase
      end
      `RV32_OP_OP_IMM: begin
        rd     = instr[11:7];
        rd_val = alu_model(f3, instr[30] && (f3 == 3'b101), a, imm_i);
      end
      `RV32_OP_OP: begin
        rd     = instr[11:7];
        rd_val = alu_model(f3, instr[30], a, b);
      end
      default: begin
      end
    endcase
  endfunction

  task automatic report_mismatch(input string name, input rv32_pkg::word_t expected,
                                 input rv32_pkg::word_t actual);
    value_errors++;
    $display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
  endtask

  // the data memory takes stores on the edge lane by lane
  always @(posedge clk) begin
    if (datamem_wr != 4'b0000) begin
      dmem[data_addr[9:2]] <= merge_bytes(dmem[data_addr[9:2]], data_out, datamem_wr);
    end
  end

  // outputs are stable at the falling edge midway through each retire cycle
  always @(negedge clk) begin : compare_step
    rv32_pkg::word_t     next_pc;
    rv32_pkg::reg_addr_t rd;
    rv32_pkg::word_t     rd_val;
    rv32_pkg::word_t     st_addr;
    rv32_pkg::byte_en_t  st_en;
    rv32_pkg::word_t     st_data;
    if (running && !done) begin
      reference_step(imem[model_pc[9:2]], model_pc, model_regs, model_mem,
                     next_pc, rd, rd_val, st_addr, st_en, st_data);
      assert (instr_addr === model_pc) else report_mismatch("instr_addr", model_pc, instr_addr);
      assert (datamem_wr === st_en)
        else report_mismatch("datamem_wr", {28'b0, st_en}, {28'b0, datamem_wr});
      if (st_en != 4'b0000) begin
        assert (data_addr === st_addr) else report_mismatch("data_addr", st_addr, data_addr);
        assert ((data_out & lane_mask(st_en)) === (st_data & lane_mask(st_en)))
          else report_mismatch("data_out", st_data & lane_mask(st_en),
                               data_out & lane_mask(st_en));
      end
      // the model retires the instruction just as the DUT will on the next edge
      if (rd != 5'd0) begin
        model_regs[rd] = rd_val;
      end
      if (st_en != 4'b0000) begin
        model_mem[st_addr[9:2]] = merge_bytes(model_mem[st_addr[9:2]], st_data, st_en);
      end
      // a pc that maps onto itself is the closing self-loop
      if (next_pc == model_pc) begin
        done = 1'b1;
      end
      model_pc = next_pc;
    end
  end

  initial begin : main_sequence
    int          idx;
    int          kind;
    int          rd;
    int          rs1;
    int          rs2;
    int          imm;
    int          offset;
    int          cycles;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [6:0]  u_op;
    clk          = 1'b0;
    rst_n        = 1'b0;
    running      = 1'b0;
    done         = 1'b0;
    value_errors = 0;
    mem_errors   = 0;
    timeouts     = 0;
    model_pc     = `RV32_RESET_PC;
    idx          = $urandom(32'h73663ff6);
    for (int i = 0; i < 256; i++) begin
      dmem[i]      = $urandom;
      model_mem[i] = dmem[i];
      imem[i]      = '0;
      is_target[i] = 1'b0;
    end
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    // the reset vector holds a word store of x0 that decode must keep off while reset is low
    idx = 0;
    imem[idx] = s_type(4 * ($urandom % 256), 0, 0, `RV32_F3_SW);
    idx++;
    // prologue sets the data base in x1 and random values in x2 to x30
    imem[idx] = i_type(DATA_BASE, 0, 3'b000, 1, `RV32_OP_OP_IMM);
    idx++;
    for (int r = 2; r < 31; r++) begin
      imem[idx]     = u_type($urandom, r, `RV32_OP_LUI);
      imem[idx + 1] = i_type($urandom, r, 3'b000, r, `RV32_OP_OP_IMM);
      idx += 2;
    end
    // x31 is kept for auipc so a jalr always sees the address of its own pair
    while (idx < LAST_IDX) begin
      kind = $urandom % 10;
      rd   = 2 + $urandom % 29;
      rs1  = $urandom % 31;
      rs2  = $urandom % 31;
      f3   = 3'($urandom % 8);
      // jumps need room before the self-loop
      if (kind >= 7 && idx > LAST_IDX - 8) begin
        kind = 0;
      end
      // landing on a jalr without its auipc would jump through a stale x31
      if (kind == 9 && is_target[idx + 1]) begin
        kind = 0;
      end
      case (kind)
        3: begin
          if (f3 == 3'b001) begin
            imm = $urandom % 32;
          end else if (f3 == 3'b101) begin
            imm = (($urandom % 2) << 10) | ($urandom % 32);
          end else begin
            imm = $urandom % 4096;
          end
          imem[idx] = i_type(imm, rs1, f3, rd, `RV32_OP_OP_IMM);
        end
        4: begin
          u_op = ($urandom % 2 == 1) ? `RV32_OP_LUI : `RV32_OP_AUIPC;
          imem[idx] = u_type($urandom, rd, u_op);
        end
        5: begin
          // 0, 1, 2, 4, 5 are lb, lh, lw, lbu, lhu
          f3 = 3'($urandom % 5);
          if (f3 > 3'd2) begin
            f3 = f3 + 3'd1;
          end
          imem[idx] = i_type(data_offset(f3[1:0]), 1, f3, rd, `RV32_OP_LOAD);
        end
        6: begin
          f3 = 3'($urandom % 3);
          imem[idx] = s_type(data_offset(f3[1:0]), rs2, 1, f3);
        end
        7: begin
          if (f3 == 3'b010 || f3 == 3'b011) begin
            f3 = 3'b000;
          end
          // equal operands make eq and ge conditions hit both outcomes
          if ($urandom % 3 == 0) begin
            rs2 = rs1;
          end
          offset = 8 + 4 * ($urandom % 3);
          imem[idx] = b_type(offset, rs2, rs1, f3);
          is_target[idx + offset / 4] = 1'b1;
        end
        8: begin
          offset = 8 + 4 * ($urandom % 3);
          imem[idx] = j_type(offset, rd);
          is_target[idx + offset / 4] = 1'b1;
        end
        9: begin
          // an odd offset checks that jalr clears bit 0 of its target
          offset = 8 + 4 * ($urandom % 4) + ($urandom % 2);
          imem[idx]     = u_type(0, 31, `RV32_OP_AUIPC);
          imem[idx + 1] = i_type(offset, 31, 3'b000, rd, `RV32_OP_JALR);
          is_target[idx + offset / 4] = 1'b1;
          idx++;
        end
        default: begin
          f7 = ((f3 == 3'b000 || f3 == 3'b101) && ($urandom % 2 == 1)) ? 7'b0100000 : 7'b0;
          imem[idx] = r_type(f7, rs2, rs1, f3, rd);
        end
      endcase
      idx++;
    end
    imem[idx] = j_type(0, 0);
    // pc sits on the reset vector and stores stay off while reset is held
    for (int i = 0; i < 3; i++) begin
      @(posedge clk);
      @(negedge clk);
      assert (instr_addr === `RV32_RESET_PC)
        else report_mismatch("instr_addr", `RV32_RESET_PC, instr_addr);
      assert (datamem_wr === 4'b0000)
        else report_mismatch("datamem_wr", 32'd0, {28'b0, datamem_wr});
    end
    @(posedge clk);
    rst_n   <= 1'b1;
    running = 1'b1;
    cycles  = 0;
    while (!done && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    if (!done) begin
      timeouts++;
      $display("error: the program did not reach its self-loop within %0d cycles",
               TIMEOUT_CYCLES);
    end
    running = 1'b0;
    for (int i = 0; i < 256; i++) begin
      assert (dmem[i] === model_mem[i]) else begin
        mem_errors++;
        $display("mismatch at %0t: dmem[%0d] expected %h actual %h",
                 $time, i, model_mem[i], dmem[i]);
      end
    end
    $display("errors: %0d value mismatches, %0d memory mismatches, %0d timeouts",
             value_errors, mem_errors, timeouts);
    if (value_errors + mem_errors + timeouts == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+src
src/rv32_pkg.sv
src/rv32_regfile.sv
src/rv32_fetch.sv
src/rv32_decode.sv
src/rv32_execute.sv
src/rv32_mem_wb.sv
src/rv32_core.sv
verif/rv32_tb.sv
